/* source/fdc_cmd_if.sv */
////////////////////////////////////////////////////////////
// FDC command interface
// Links the host register file with the sector sequencer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface fdc_cmd_if
	import fdc_pkg::*;
();
	// Register file side
	cmd_word_t  command;
	logic [7:0] track;
	logic [7:0] sector;
	logic       start;
	logic       abort;

	// Sequencer side
	logic [7:0] sector_next;
	logic       sector_load;
	logic       done;
	logic       busy;
	logic       drq;
	logic       not_ready;
	logic       wprot;
	logic       rnf;

	modport regs (
		output command, track, sector, start, abort,
		input  sector_next, sector_load, done, busy, drq, not_ready, wprot, rnf
	);

	modport seq (
		input  command, track, sector, start, abort,
		output sector_next, sector_load, done, busy, drq, not_ready, wprot, rnf
	);

endinterface

/* source/fdc_ms_tick.sv */
////////////////////////////////////////////////////////////
// Millisecond timebase
// Divides the system clock down to a single-cycle enable
// once per millisecond for the head settle wait
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fdc_ms_tick #(
	parameter int CLKS_PER_MS = 8000
) (
	input  logic clk,
	input  logic reset,
	output logic tick
);

	// At least one bit even for a divide by one
	localparam int CNT_W = (CLKS_PER_MS > 1) ? $clog2(CLKS_PER_MS) : 1;

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			tick  <= 1'b0;
		end else if (count == CNT_W'(CLKS_PER_MS - 1)) begin
			// Wrap and flag the end of this millisecond
			count <= '0;
			tick  <= 1'b1;
		end else begin
			count <= count + 1'b1;
			tick  <= 1'b0;
		end
	end

endmodule

/* source/fdc_pkg.sv */
////////////////////////////////////////////////////////////
// FDC shared definitions
// Command class codes, the command word with its sector
// and force-interrupt views, status bit positions, register
// addresses and the sequencer timing limits
////////////////////////////////////////////////////////////

package fdc_pkg;

	// Top two bits of a read-sector or write-sector command
	localparam logic [1:0] CLASS_SECTOR = 2'b10;
	// Top four bits of a force-interrupt command
	localparam logic [3:0] CLASS_FORCE_INT = 4'b1101;

	// The same command byte read as a type II command or as a force interrupt
	typedef union packed {
		struct packed {
			logic [1:0] cmd_class;
			logic       write;
			logic       multiple;
			logic       side;
			logic       delay_15ms;
			// On side-select parts this bit is the SSO output value instead
			logic       side_compare;
			logic       spare;
		} sec;
		struct packed {
			logic [3:0] cmd_class;
			logic [3:0] cond;
		} fint;
	} cmd_word_t;

	// Status register bit positions
	localparam int STAT_BUSY        = 0;
	localparam int STAT_DRQ         = 1;
	localparam int STAT_LOST_DATA   = 2;
	localparam int STAT_CRC         = 3;
	localparam int STAT_RNF         = 4;
	localparam int STAT_RECORD_TYPE = 5;
	localparam int STAT_WPROT       = 6;
	localparam int STAT_NOT_READY   = 7;

	// Head settle time in millisecond ticks
	localparam int SETTLE_MS   = 15;
	// Index pulses seen in search before the record is given up
	localparam int INDEX_LIMIT = 5;

	// Host register map
	localparam logic [1:0] ADDR_CMD_STATUS = 2'd0;
	localparam logic [1:0] ADDR_TRACK      = 2'd1;
	localparam logic [1:0] ADDR_SECTOR     = 2'd2;
	localparam logic [1:0] ADDR_DATA       = 2'd3;

endpackage

/* source/fdc_registers.sv */
////////////////////////////////////////////////////////////
// FDC host register file
// Command, track, sector and data registers with command
// decode, force interrupt, status readback and the INTRQ
// latch
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fdc_registers
	import fdc_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic [1:0] addr,
	input  logic [7:0] wdata,
	input  logic       wr,
	input  logic       rd,
	output logic [7:0] rdata,
	output logic       intrq,
	fdc_cmd_if.regs    seq
);

	cmd_word_t  wr_word;
	logic       cmd_wr;
	logic       is_sector;
	logic       is_force_int;
	logic [7:0] data;
	logic [7:0] status;

	// The written byte is looked at through both views of the command word
	assign wr_word      = wdata;
	assign cmd_wr       = wr && (addr == ADDR_CMD_STATUS);
	assign is_sector    = (wr_word.sec.cmd_class == CLASS_SECTOR);
	assign is_force_int = (wr_word.fint.cmd_class == CLASS_FORCE_INT);

	always_ff @(posedge clk) begin
		if (reset) begin
			seq.command <= '0;
			seq.track   <= '0;
			seq.sector  <= '0;
			seq.start   <= 1'b0;
			seq.abort   <= 1'b0;
			data        <= '0;
			intrq       <= 1'b0;
		end else begin
			// A sector command is dropped while the sequencer is still busy
			seq.start <= cmd_wr && is_sector && !seq.busy;
			// Force interrupt is taken in any state
			seq.abort <= cmd_wr && is_force_int;
			if (cmd_wr && (is_force_int || !seq.busy))
				seq.command <= wr_word;
			if (wr && (addr == ADDR_TRACK))
				seq.track <= wdata;
			if (wr && (addr == ADDR_SECTOR))
				seq.sector <= wdata;
			// Multiple-sector advance from the sequencer wins over a host write
			if (seq.sector_load)
				seq.sector <= seq.sector_next;
			if (wr && (addr == ADDR_DATA))
				data <= wdata;
			// A new event beats a status read in the same cycle
			if (seq.done || seq.abort)
				intrq <= 1'b1;
			else if (rd && (addr == ADDR_CMD_STATUS))
				intrq <= 1'b0;
		end
	end

	// Status byte as seen by a type II command
	always_comb begin
		status                   = '0;
		status[STAT_BUSY]        = seq.busy;
		status[STAT_DRQ]         = seq.drq;
		// No data path, so data is never lost and no CRC is checked
		status[STAT_LOST_DATA]   = 1'b0;
		status[STAT_CRC]         = 1'b0;
		status[STAT_RNF]         = seq.rnf;
		// Deleted data marks are not modelled
		status[STAT_RECORD_TYPE] = 1'b0;
		status[STAT_WPROT]       = seq.wprot;
		status[STAT_NOT_READY]   = seq.not_ready;
	end

	always_comb begin
		case (addr)
			ADDR_CMD_STATUS: rdata = status;
			ADDR_TRACK:      rdata = seq.track;
			ADDR_SECTOR:     rdata = seq.sector;
			default:         rdata = data;
		endcase
	end

endmodule

/* source/fdc_sector_cmd.sv */
////////////////////////////////////////////////////////////
// FDC sector command sequencer
// Runs read-sector and write-sector commands: ready check,
// head load and settle, write protect check, ID search with
// index timeout, DRQ window and multiple-sector advance
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fdc_sector_cmd
	import fdc_pkg::*;
#(
	parameter bit HAS_SIDE_SELECT = 0
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       tick,
	input  logic       index_n,
	input  logic       ready_n,
	input  logic       wprot_n,
	input  logic [7:0] id_track,
	input  logic       id_side,
	input  logic [7:0] id_sector,
	input  logic       id_valid,
	output logic       hld,
	output logic       sso,
	fdc_cmd_if.seq     cmd
);

	localparam int WAIT_W  = $clog2(SETTLE_MS + 1);
	localparam int INDEX_W = $clog2(INDEX_LIMIT + 1);

	localparam logic [2:0] ST_IDLE     = 3'd0;
	localparam logic [2:0] ST_PREPARE  = 3'd1;
	localparam logic [2:0] ST_SETTLE   = 3'd2;
	localparam logic [2:0] ST_SEARCH   = 3'd3;
	localparam logic [2:0] ST_TRANSFER = 3'd4;

	logic [2:0]         state;
	logic [WAIT_W-1:0]  wait_count;
	logic [INDEX_W-1:0] index_count;
	logic               index_last;
	logic               index_fall;
	logic               side_ok;
	logic               id_match;

	assign index_fall = index_last && !index_n;

	// Side-select parts drive the side and never compare it
	assign side_ok = HAS_SIDE_SELECT || !cmd.command.sec.side_compare ||
		(id_side == cmd.command.sec.side);

	// The sector register is one cycle late after an advance, so that cycle is skipped
	assign id_match = id_valid && !cmd.sector_load && side_ok &&
		(id_track == cmd.track) && (id_sector == cmd.sector);

	assign cmd.busy = (state != ST_IDLE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state           <= ST_IDLE;
			cmd.drq         <= 1'b0;
			cmd.done        <= 1'b0;
			cmd.sector_load <= 1'b0;
			cmd.not_ready   <= 1'b0;
			cmd.wprot       <= 1'b0;
			cmd.rnf         <= 1'b0;
			hld             <= 1'b0;
			sso             <= 1'b0;
			index_last      <= 1'b1;
		end else begin
			cmd.done        <= 1'b0;
			cmd.sector_load <= 1'b0;
			index_last      <= index_n;
			if (cmd.abort) begin
				// Force interrupt drops the command without a done strobe
				state   <= ST_IDLE;
				cmd.drq <= 1'b0;
				hld     <= 1'b0;
			end else begin
				case (state)
					ST_IDLE: begin
						if (cmd.start) begin
							cmd.not_ready <= 1'b0;
							cmd.wprot     <= 1'b0;
							cmd.rnf       <= 1'b0;
							state         <= ST_PREPARE;
						end
					end
					ST_PREPARE: begin
						if (ready_n) begin
							cmd.not_ready <= 1'b1;
							cmd.done      <= 1'b1;
							state         <= ST_IDLE;
						end else begin
							hld <= 1'b1;
							if (HAS_SIDE_SELECT)
								sso <= cmd.command.sec.side_compare;
							// Settle counts whole ticks, so it runs short by under 1 ms
							wait_count <= cmd.command.sec.delay_15ms ? WAIT_W'(SETTLE_MS) : '0;
							state      <= ST_SETTLE;
						end
					end
					ST_SETTLE: begin
						if (wait_count != '0) begin
							if (tick)
								wait_count <= wait_count - 1'b1;
						end else if (cmd.command.sec.write && !wprot_n) begin
							cmd.wprot <= 1'b1;
							cmd.done  <= 1'b1;
							hld       <= 1'b0;
							state     <= ST_IDLE;
						end else begin
							index_count <= '0;
							state       <= ST_SEARCH;
						end
					end
					ST_SEARCH: begin
						if (index_fall)
							index_count <= index_count + 1'b1;
						// Timeout is checked before a match, as on the real part
						if (index_count == INDEX_W'(INDEX_LIMIT)) begin
							cmd.rnf  <= 1'b1;
							cmd.done <= 1'b1;
							hld      <= 1'b0;
							state    <= ST_IDLE;
						end else if (id_match) begin
							state <= ST_TRANSFER;
						end
					end
					ST_TRANSFER: begin
						// DRQ only marks where the data field would flow
						if (id_valid) begin
							cmd.drq <= 1'b1;
						end else begin
							cmd.drq <= 1'b0;
							if (cmd.command.sec.multiple) begin
								cmd.sector_next <= cmd.sector + 1'b1;
								cmd.sector_load <= 1'b1;
								index_count     <= '0;
								state           <= ST_SEARCH;
							end else begin
								cmd.done <= 1'b1;
								hld      <= 1'b0;
								state    <= ST_IDLE;
							end
						end
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

endmodule

/* source/fdc_top.sv */
////////////////////////////////////////////////////////////
// FDC sector command subsystem
// Millisecond timebase, host register file and sector
// sequencer behind plain host and drive ports
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fdc_top #(
	parameter int CLKS_PER_MS     = 8000,
	parameter bit HAS_SIDE_SELECT = 0
) (
	input  logic       clk,
	input  logic       reset,
	// Host bus
	input  logic [1:0] addr,
	input  logic [7:0] wdata,
	input  logic       wr,
	input  logic       rd,
	output logic [7:0] rdata,
	output logic       intrq,
	output logic       drq,
	// Drive side with the ID fields already decoded
	input  logic       index_n,
	input  logic       ready_n,
	input  logic       wprot_n,
	input  logic [7:0] id_track,
	input  logic       id_side,
	input  logic [7:0] id_sector,
	input  logic       id_valid,
	output logic       hld,
	output logic       sso
);

	logic tick;

	fdc_cmd_if cmd_if ();

	fdc_ms_tick #(
		.CLKS_PER_MS(CLKS_PER_MS)
	) i_ms_tick (
		.clk  (clk),
		.reset(reset),
		.tick (tick)
	);

	fdc_registers i_registers (
		.clk  (clk),
		.reset(reset),
		.addr (addr),
		.wdata(wdata),
		.wr   (wr),
		.rd   (rd),
		.rdata(rdata),
		.intrq(intrq),
		.seq  (cmd_if.regs)
	);

	fdc_sector_cmd #(
		.HAS_SIDE_SELECT(HAS_SIDE_SELECT)
	) i_sector_cmd (
		.clk      (clk),
		.reset    (reset),
		.tick     (tick),
		.index_n  (index_n),
		.ready_n  (ready_n),
		.wprot_n  (wprot_n),
		.id_track (id_track),
		.id_side  (id_side),
		.id_sector(id_sector),
		.id_valid (id_valid),
		.hld      (hld),
		.sso      (sso),
		.cmd      (cmd_if.seq)
	);

	// DRQ also goes to the host pin, not just the status byte
	assign drq = cmd_if.drq;

endmodule

/* sources.f */
source/fdc_pkg.sv
source/fdc_cmd_if.sv
source/fdc_ms_tick.sv
source/fdc_registers.sv
source/fdc_sector_cmd.sv
source/fdc_top.sv
verification/fdc_tb_assert.sv
verification/fdc_tb.sv

/* verification/fdc_tb.sv */
////////////////////////////////////////////////////////////
// FDC sector command testbench
// Random read-sector and write-sector commands against a
// spinning drive model, with force interrupts, checked on
// INTRQ against a reference model of status and sector
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fdc_tb
	import fdc_pkg::*;
#(
	// Set to 1 at elaboration for the side-select variant
	parameter bit HAS_SIDE_SELECT = 0
);

	localparam int  CLKS_PER_MS = 20;
	localparam int  NUM_CMDS    = 40;
	localparam int  MAX_FIELDS  = 4;
	localparam real PERIOD_NS   = 100.0;
	localparam real WATCHDOG_NS = NUM_CMDS * (SETTLE_MS + 10) * CLKS_PER_MS * PERIOD_NS * 10.0;

	logic clk, reset, wr, rd, intrq, drq, hld, sso;
	logic index_n, ready_n, wprot_n, id_side, id_valid;
	logic [1:0] addr;
	logic [7:0] wdata, rdata, id_track, id_sector;

	int   errors;
	int   checks;
	int   elapsed;
	logic finished;
	logic hld_seen;
	logic drq_seen;
	logic exp_sso;

	// Current scenario with its command, registers, drive state and one track of ID fields
	cmd_word_t  cmd_word;
	logic [7:0] trk;
	logic [7:0] sec;
	logic       ready;
	logic       prot;
	logic       do_abort;
	int         abort_at;
	int         nf;
	int         idx_space;
	logic [7:0] f_track[MAX_FIELDS];
	logic       f_side[MAX_FIELDS];
	logic [7:0] f_sector[MAX_FIELDS];
	int         f_gap[MAX_FIELDS];
	int         f_len[MAX_FIELDS];

	fdc_top #(
		.CLKS_PER_MS    (CLKS_PER_MS),
		.HAS_SIDE_SELECT(HAS_SIDE_SELECT)
	) i_fdc_top (
		.clk(clk), .reset(reset), .addr(addr), .wdata(wdata), .wr(wr), .rd(rd),
		.rdata(rdata), .intrq(intrq), .drq(drq), .index_n(index_n), .ready_n(ready_n),
		.wprot_n(wprot_n), .id_track(id_track), .id_side(id_side), .id_sector(id_sector),
		.id_valid(id_valid), .hld(hld), .sso(sso)
	);

	bind fdc_sector_cmd fdc_tb_assert i_sector_assert (
		.clk(clk), .reset(reset), .busy(cmd.busy), .drq(cmd.drq), .done(cmd.done), .hld(hld)
	);

	always #(PERIOD_NS / 2) clk = ~clk;

	// Outputs are sampled just after the edge once they have settled
	task automatic step();
		@(posedge clk);
		#1;
		elapsed++;
		if (hld)
			hld_seen = 1'b1;
		if (drq)
			drq_seen = 1'b1;
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic host_write(input logic [1:0] a, input logic [7:0] d);
		addr  = a;
		wdata = d;
		wr    = 1'b1;
		step();
		wr = 1'b0;
	endtask

	// One clock of the drive with the force interrupt strobe slotted in when due
	task automatic drive_cycle(input logic valid, input int f, input logic idx);
		if (!finished) begin
			index_n   = !idx;
			id_valid  = valid;
			id_track  = f_track[f];
			id_side   = f_side[f];
			id_sector = f_sector[f];
			wr        = do_abort && (elapsed == abort_at);
			step();
			if (intrq)
				finished = 1'b1;
		end
	endtask

	// True when some field on the track carries this sector under the command's rules
	function automatic bit has_id(input logic [7:0] s);
		bit found;
		int f;
		found = 1'b0;
		for (f = 0; f < nf; f++)
			if (f_track[f] == trk && f_sector[f] == s && (HAS_SIDE_SELECT ||
				!cmd_word.sec.side_compare || f_side[f] == cmd_word.sec.side))
				found = 1'b1;
		return found;
	endfunction

	task automatic build_scenario();
		int f;
		cmd_word                  = '0;
		cmd_word.sec.cmd_class    = CLASS_SECTOR;
		cmd_word.sec.write        = $urandom % 2;
		cmd_word.sec.multiple     = $urandom % 2;
		cmd_word.sec.side         = $urandom % 2;
		cmd_word.sec.delay_15ms   = ($urandom % 3) == 0;
		cmd_word.sec.side_compare = $urandom % 2;
		trk   = $urandom % 80;
		sec   = 1 + $urandom % 200;
		ready = ($urandom % 6) != 0;
		prot  = ($urandom % 4) == 0;
		// An abort lands in settle or early search before the command could end
		do_abort  = ready && cmd_word.sec.delay_15ms && !(cmd_word.sec.write && prot) &&
			(($urandom % 3) == 0);
		abort_at  = 5 + $urandom % 320;
		nf        = 1 + $urandom % MAX_FIELDS;
		idx_space = 10 + $urandom % 20;
		for (f = 0; f < MAX_FIELDS; f++) begin
			// Nearby sectors leave runs for multiple mode to follow
			f_sector[f] = sec + $urandom % 4;
			f_track[f]  = (do_abort || ($urandom % 4) == 0) ? trk ^ 8'h01 : trk;
			f_side[f]   = $urandom % 2;
			f_gap[f]    = 2 + $urandom % 5;
			f_len[f]    = 2 + $urandom % 5;
		end
	endtask

	// Reference model of the type II status byte and the final sector register
	task automatic predict(output logic [7:0] exp_status, output logic [7:0] exp_sector,
		output bit exp_match);
		exp_status = '0;
		exp_sector = sec;
		exp_match  = 1'b0;
		if (!do_abort) begin
			if (!ready) begin
				exp_status[STAT_NOT_READY] = 1'b1;
			end else if (cmd_word.sec.write && prot) begin
				exp_status[STAT_WPROT] = 1'b1;
			end else begin
				exp_match = has_id(sec);
				// Multiple mode walks up until a sector is missing, then times out
				if (cmd_word.sec.multiple) begin
					while (has_id(exp_sector))
						exp_sector++;
					exp_status[STAT_RNF] = 1'b1;
				end else if (!exp_match) begin
					exp_status[STAT_RNF] = 1'b1;
				end
			end
		end
	endtask

	task automatic run_command(input int n);
		logic [7:0] exp_status;
		logic [7:0] exp_sector;
		logic [7:0] got_status;
		logic [7:0] got_sector;
		cmd_word_t  fint_word;
		bit         exp_match;
		int         cmd_cycles;
		int         pulses;
		int         f;
		int         i;
		build_scenario();
		predict(exp_status, exp_sector, exp_match);
		if (ready && HAS_SIDE_SELECT)
			exp_sso = cmd_word.sec.side_compare;
		ready_n = !ready;
		wprot_n = !prot;
		host_write(ADDR_TRACK, trk);
		host_write(ADDR_SECTOR, sec);
		hld_seen = 1'b0;
		drq_seen = 1'b0;
		host_write(ADDR_CMD_STATUS, cmd_word);
		elapsed  = 0;
		finished = 1'b0;
		pulses   = 0;
		// The force interrupt byte sits on the bus and only the strobe moves
		fint_word                = '0;
		fint_word.fint.cmd_class = CLASS_FORCE_INT;
		addr  = ADDR_CMD_STATUS;
		wdata = fint_word;
		while (!finished) begin
			// Each revolution opens with one index pulse
			pulses++;
			for (i = 0; i < 2; i++)
				drive_cycle(1'b0, 0, 1'b1);
			for (f = 0; f < nf; f++) begin
				for (i = 0; i < f_gap[f]; i++)
					drive_cycle(1'b0, f, 1'b0);
				for (i = 0; i < f_len[f]; i++)
					drive_cycle(1'b1, f, 1'b0);
			end
			for (i = 0; i < idx_space; i++)
				drive_cycle(1'b0, 0, 1'b0);
		end
		cmd_cycles = elapsed;
		id_valid   = 1'b0;
		index_n    = 1'b1;
		wr         = 1'b0;
		addr       = ADDR_SECTOR;
		#1;
		got_sector = rdata;
		addr       = ADDR_CMD_STATUS;
		rd         = 1'b1;
		#1;
		got_status = rdata;
		step();
		rd = 1'b0;
		check_value($sformatf("status (cmd %0d)", n), got_status, exp_status);
		check_value($sformatf("sector (cmd %0d)", n), got_sector, exp_sector);
		check_value($sformatf("intrq after read (cmd %0d)", n), intrq, 1'b0);
		check_value($sformatf("drq (cmd %0d)", n), drq, 1'b0);
		check_value($sformatf("hld (cmd %0d)", n), hld, 1'b0);
		check_value($sformatf("sso (cmd %0d)", n), sso, exp_sso);
		check_value($sformatf("hld_seen (cmd %0d)", n), hld_seen, ready);
		// Without the settle wait the search opens ahead of the first field
		if (!exp_match)
			check_value($sformatf("drq_seen (cmd %0d)", n), drq_seen, 1'b0);
		else if (!cmd_word.sec.delay_15ms)
			check_value($sformatf("drq_seen (cmd %0d)", n), drq_seen, 1'b1);
		// The pulse at the command start comes before the search and adds one to the limit
		if (exp_status[STAT_RNF])
			check_value($sformatf("index_pulses_over_limit (cmd %0d)", n),
				pulses > INDEX_LIMIT, 1'b1);
		// Settle runs on whole ticks, so it may come in up to one millisecond short
		if (ready && cmd_word.sec.delay_15ms && !do_abort)
			check_value($sformatf("settle_long_enough (cmd %0d)", n),
				cmd_cycles >= (SETTLE_MS - 1) * CLKS_PER_MS, 1'b1);
	endtask

	initial begin
		int seed;
		int n;
		seed      = $urandom(32'hed2b);
		clk       = 1'b0;
		reset     = 1'b1;
		addr      = ADDR_CMD_STATUS;
		wdata     = '0;
		wr        = 1'b0;
		rd        = 1'b0;
		index_n   = 1'b1;
		ready_n   = 1'b1;
		wprot_n   = 1'b1;
		id_track  = '0;
		id_side   = 1'b0;
		id_sector = '0;
		id_valid  = 1'b0;
		errors    = 0;
		checks    = 0;
		exp_sso   = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		check_value("status after reset", rdata, 8'h00);
		check_value("intrq after reset", intrq, 1'b0);
		check_value("drq after reset", drq, 1'b0);
		check_value("hld after reset", hld, 1'b0);
		check_value("sso after reset", sso, 1'b0);
		for (n = 0; n < NUM_CMDS; n++)
			run_command(n);
		$display("Commands: %0d, checks: %0d, errors: %0d", NUM_CMDS, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// Hard limit scaled from the worst command length
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the commands did not all finish before the watchdog limit");
		$display("TB FAILED");
		$finish;
	end

endmodule

/* verification/fdc_tb_assert.sv */
////////////////////////////////////////////////////////////
// Sector sequencer assertions
// Handshake and output rules of the sequencer, bound into
// every fdc_sector_cmd instance by the testbench
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fdc_tb_assert (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic drq,
	input logic done,
	input logic hld
);

	// DRQ only opens inside a running command
	drq_needs_busy: assert property (@(posedge clk) disable iff (reset) !busy |-> !drq)
		else $error("DRQ is high while the sequencer is idle");

	// Done is a strobe and never stretches
	done_single_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("Done stayed high for two cycles");

	// The head stays loaded for the whole data window
	hld_covers_drq: assert property (@(posedge clk) disable iff (reset) drq |-> hld)
		else $error("Head load dropped while DRQ is high");

endmodule
